// ==== verification/rv_core_trace.txt ====
# I <word address> <instruction>, all hex
# E <pc> <rd_we> <rd> <rd_data> <next_pc> <flow>, all hex, flow 0 plain 1 call 2 ret 3 tail
I 00 ffb00293
I 01 00300313
I 02 006283b3
I 03 40530433
I 04 0062a4b3
I 05 0062b533
I 06 006315b3
I 07 4012d613
I 08 01c2d693
I 09 0062c733
I 0a 07036793
I 0b 0f02f813
I 0c 123458b7
I 0d 00001917
I 0e 00500013
I 0f 000009b3
I 10 00630463
I 12 00628463
I 13 00629463
I 15 00631463
I 16 0062c463
I 18 00534463
I 19 00535463
I 1b 0062d463
I 1c 00536463
I 1e 0062e463
I 1f 0062f463
I 21 00537463
I 22 04502023
I 23 046001a3
I 24 04501323
I 25 04002a03
I 26 04000a83
I 27 04004b03
I 28 04601b83
I 29 04605c03
I 2a 10000c93
I 2b 10800d13
I 2c 010000ef
I 2d 000c80e7
I 2e 0000006f
I 30 00008067
I 40 000d0067
I 42 00008067
E 00000000 1 05 fffffffb 00000004 0
E 00000004 1 06 00000003 00000008 0
E 00000008 1 07 fffffffe 0000000c 0
E 0000000c 1 08 00000008 00000010 0
E 00000010 1 09 00000001 00000014 0
E 00000014 1 0a 00000000 00000018 0
E 00000018 1 0b 00000018 0000001c 0
E 0000001c 1 0c fffffffd 00000020 0
E 00000020 1 0d 0000000f 00000024 0
E 00000024 1 0e fffffff8 00000028 0
E 00000028 1 0f 00000073 0000002c 0
E 0000002c 1 10 000000f0 00000030 0
E 00000030 1 11 12345000 00000034 0
E 00000034 1 12 00001034 00000038 0
E 00000038 1 00 00000005 0000003c 0
E 0000003c 1 13 00000000 00000040 0
E 00000040 0 00 00000000 00000048 0
E 00000048 0 00 00000000 0000004c 0
E 0000004c 0 00 00000000 00000054 0
E 00000054 0 00 00000000 00000058 0
E 00000058 0 00 00000000 00000060 0
E 00000060 0 00 00000000 00000064 0
E 00000064 0 00 00000000 0000006c 0
E 0000006c 0 00 00000000 00000070 0
E 00000070 0 00 00000000 00000078 0
E 00000078 0 00 00000000 0000007c 0
E 0000007c 0 00 00000000 00000084 0
E 00000084 0 00 00000000 00000088 0
E 00000088 0 00 00000000 0000008c 0
E 0000008c 0 00 00000000 00000090 0
E 00000090 0 00 00000000 00000094 0
E 00000094 1 14 03fffffb 00000098 0
E 00000098 1 15 fffffffb 0000009c 0
E 0000009c 1 16 000000fb 000000a0 0
E 000000a0 1 17 fffffffb 000000a4 0
E 000000a4 1 18 0000fffb 000000a8 0
E 000000a8 1 19 00000100 000000ac 0
E 000000ac 1 1a 00000108 000000b0 0
E 000000b0 1 01 000000b4 000000c0 1
E 000000c0 1 00 000000c4 000000b4 2
E 000000b4 1 01 000000b8 00000100 1
E 00000100 1 00 00000104 00000108 3
E 00000108 1 00 0000010c 000000b8 2
E 000000b8 1 00 000000bc 000000b8 0

// ==== rv_core.f ====
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_imm_gen.sv
hdl/rv_alu.sv
hdl/rv_branch_unit.sv
hdl/rv_regfile.sv
hdl/rv_fetch_unit.sv
hdl/rv_data_ram.sv
hdl/rv_core_top.sv
verification/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_decoder.sv
  - hdl/rv_imm_gen.sv
  - hdl/rv_alu.sv
  - hdl/rv_branch_unit.sv
  - hdl/rv_regfile.sv
  - hdl/rv_fetch_unit.sv
  - hdl/rv_data_ram.sv
  - hdl/rv_core_top.sv
  - target: simulation
    files:
      - verification/tb_rv_core.sv

// ==== verification/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int imem_words = 256;

    logic            clk;
    logic            reset;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    retire_t         retire;

    logic [xlen-1:0] imem [imem_words];
    retire_t         exp_q [$];             // expected records in retire order
    int              n_exp;
    int              exp_idx;
    int              errors;
    int              cycles;
    int              cycle_limit;
    logic [xlen-1:0] prev_next_pc;
    logic            have_prev;

    rv_core_top uut (
        .clk    (clk),
        .reset  (reset),
        .pc     (pc),
        .inst   (inst),
        .retire (retire)
    );

    // pc is unknown until the first reset edge, so answer with a nop
    assign inst = $isunknown(pc) ? 32'h0000_0013 : imem[pc[9:2]];

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic load_trace();
        int              fd;
        int              n;
        int              waddr;
        string           tag;
        string           rest;
        logic [xlen-1:0] word;
        logic [xlen-1:0] f_pc;
        logic [xlen-1:0] f_data;
        logic [xlen-1:0] f_next;
        logic [4:0]      f_rd;
        logic            f_we;
        logic [1:0]      f_flow;
        for (int i = 0; i < imem_words; i++)
            imem[i] = {i[19:0], 12'h013};    // holes decode as op-imm writes to x0
        fd = $fopen("verification/rv_core_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file verification/rv_core_trace.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "I") begin
                n = $fscanf(fd, "%h %h", waddr, word);
                if (n == 2) begin
                    imem[waddr] = word;
                end else begin
                    $display("an instruction line of the trace file could not be read");
                    errors++;
                end
            end else if (tag == "E") begin
                n = $fscanf(fd, "%h %h %h %h %h %h", f_pc, f_we, f_rd, f_data, f_next, f_flow);
                if (n == 6) begin
                    exp_q.push_back('{valid: 1'b1, pc: f_pc, rd: f_rd, rd_we: f_we,
                                      rd_data: f_data, next_pc: f_next, flow: flow_e'(f_flow)});
                end else begin
                    $display("an expected record line of the trace file could not be read");
                    errors++;
                end
            end else begin
                n = $fgets(rest, fd);            // comment line
            end
        end
        $fclose(fd);
    endtask

    task automatic report_mismatch(input string field, input logic [xlen-1:0] got,
                                   input logic [xlen-1:0] want);
        $display("Mismatch at %0t: record %0d field %s is %h, expected %h",
                 $time, exp_idx, field, got, want);
        errors++;
    endtask

    task automatic check_record(input retire_t got, input retire_t want);
        assert (got.pc == want.pc)
            else report_mismatch("pc", got.pc, want.pc);
        if (have_prev) begin
            assert (got.pc == prev_next_pc)  // pc follows the last next_pc
                else report_mismatch("pc after next_pc", got.pc, prev_next_pc);
        end
        assert (got.rd_we == want.rd_we)
            else report_mismatch("rd_we", got.rd_we, want.rd_we);
        if (want.rd_we) begin
            assert (got.rd == want.rd)
                else report_mismatch("rd", got.rd, want.rd);
            assert (got.rd_data == want.rd_data)
                else report_mismatch("rd_data", got.rd_data, want.rd_data);
        end
        assert (got.next_pc == want.next_pc)
            else report_mismatch("next_pc", got.next_pc, want.next_pc);
        assert (got.flow == want.flow)
            else report_mismatch("flow", got.flow, want.flow);
        prev_next_pc = got.next_pc;
        have_prev    = 1'b1;
    endtask

    task automatic finish_run();
        $display("%0d of %0d records checked, %0d errors", exp_idx, n_exp, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d records retired",
                     cycles, exp_idx, n_exp);
            errors++;
            finish_run();
        end else if (retire.valid) begin
            check_record(retire, exp_q[exp_idx]);
            exp_idx++;
            if (exp_idx >= n_exp)
                finish_run();
        end
    end

    initial begin
        reset       = 1'b1;
        errors      = 0;
        exp_idx     = 0;
        cycles      = 0;
        have_prev   = 1'b0;
        load_trace();
        n_exp       = exp_q.size();
        cycle_limit = n_exp + 20;
        if (n_exp == 0) begin
            $display("the trace file holds no expected records");
            errors++;
            finish_run();
        end else begin
            repeat (2) @(posedge clk);
            reset <= 1'b0;
        end
    end

endmodule

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
    input  logic                    clk,
    input  logic                    reset,
    output logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] inst,
    output rv_pkg::retire_t         retire
);
    import rv_pkg::*;

    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] mem_data;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] rd_data;
    logic            taken;

    rv_fetch_unit u_fetch (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .taken    (taken),
        .alu_out  (alu_out),
        .pc       (pc),
        .pc_plus4 (pc_plus4),
        .next_pc  (next_pc)
    );

    rv_decoder u_decoder (.inst(inst), .ctrl(ctrl));

    rv_imm_gen u_imm_gen (.inst(inst), .imm(imm));

    rv_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .inst     (inst),
        .ctrl     (ctrl),
        .pc_plus4 (pc_plus4),
        .alu_out  (alu_out),
        .mem_data (mem_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_data  (rd_data)
    );

    rv_alu u_alu (
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .ctrl     (ctrl),
        .alu_out  (alu_out)
    );

    rv_branch_unit u_branch (
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .branch   (ctrl.branch),
        .taken    (taken)
    );

    rv_data_ram u_dmem (
        .clk   (clk),
        .ctrl  (ctrl),
        .addr  (alu_out),
        .wdata (rs2_data),
        .rdata (mem_data)
    );

    // one record per cycle, nothing retires while in reset
    assign retire = '{
        valid:   ~reset,
        pc:      pc,
        rd:      inst[11:7],
        rd_we:   ctrl.rd_we,
        rd_data: rd_data,
        next_pc: next_pc,
        flow:    ctrl.flow
    };

endmodule

// ==== hdl/rv_data_ram.sv ====
`timescale 1ns/1ps

module rv_data_ram (
    input  logic                    clk,
    input  rv_pkg::ctrl_t           ctrl,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rdata
);
    import rv_pkg::*;

    logic [xlen-1:0]    mem [dmem_words];
    logic [dmem_aw-1:0] word_idx;
    logic [1:0]         offs;
    logic [3:0]         be;
    logic [xlen-1:0]    wword;
    logic [xlen-1:0]    shifted;

    assign word_idx = addr[dmem_aw+1:2];
    assign offs     = addr[1:0];
    assign shifted  = mem[word_idx] >> {offs, 3'b000}; // addressed byte to lane 0

    always_comb begin
        case (ctrl.mem_size)
            mem_b, mem_bu: begin
                be    = 4'b0001 << offs;
                wword = {4{wdata[7:0]}};
            end
            mem_h, mem_hu: begin
                be    = offs[1] ? 4'b1100 : 4'b0011;
                wword = {2{wdata[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wword = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.mem_wr) begin
            for (int i = 0; i < 4; i++)
                if (be[i])
                    mem[word_idx][8*i +: 8] <= wword[8*i +: 8];
        end
    end

    always_comb begin
        if (!ctrl.mem_rd)
            rdata = '0;
        else begin
            case (ctrl.mem_size)
                mem_b:   rdata = {{24{shifted[7]}}, shifted[7:0]};
                mem_bu:  rdata = {24'd0, shifted[7:0]};
                mem_h:   rdata = {{16{shifted[15]}}, shifted[15:0]};
                mem_hu:  rdata = {16'd0, shifted[15:0]};
                default: rdata = shifted;
            endcase
        end
    end

    // one port, so a load and a store never share a cycle
    a_rd_wr_excl: assert property (@(posedge clk) !(ctrl.mem_rd && ctrl.mem_wr))
        else $error("data RAM saw mem_rd and mem_wr together");

    a_aligned: assert property (@(posedge clk)
        (ctrl.mem_rd || ctrl.mem_wr) |->
            ((ctrl.mem_size inside {mem_h, mem_hu}) ? !addr[0] :
             (ctrl.mem_size inside {mem_b, mem_bu}) ? 1'b1 : addr[1:0] == 2'b00))
        else $error("misaligned access at %h", addr);

endmodule

// ==== hdl/rv_fetch_unit.sv ====
`timescale 1ns/1ps

module rv_fetch_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::ctrl_t           ctrl,
    input  logic                    taken,
    input  logic [rv_pkg::xlen-1:0] alu_out,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] pc_plus4,
    output logic [rv_pkg::xlen-1:0] next_pc
);
    import rv_pkg::*;

    logic [xlen-1:0] target;

    assign pc_plus4 = pc + 32'd4;
    // jalr drops bit 0 of rs1 + imm
    assign target   = {alu_out[xlen-1:1], alu_out[0] & ~ctrl.a_sel_rs1};
    assign next_pc  = (ctrl.is_jump || taken) ? target : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= '0;
        else
            pc <= next_pc;
    end

    // a jump or branch target off the word grid would break fetch
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

endmodule

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::xlen-1:0] inst,
    input  rv_pkg::ctrl_t           ctrl,
    input  logic [rv_pkg::xlen-1:0] pc_plus4,
    input  logic [rv_pkg::xlen-1:0] alu_out,
    input  logic [rv_pkg::xlen-1:0] mem_data,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data,
    output logic [rv_pkg::xlen-1:0] rd_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd_addr;

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign rd_addr  = inst[11:7];

    // x0 is cleared on reset and never written
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_comb begin
        case (ctrl.wb_sel)
            wb_pc_plus4: rd_data = pc_plus4; // link address
            wb_alu:      rd_data = alu_out;
            wb_mem:      rd_data = mem_data;
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (ctrl.rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (reset)
        rs1_addr == 5'd0 |-> rs1_data == '0)
        else $error("x0 read back nonzero");

endmodule

// ==== hdl/rv_branch_unit.sv ====
`timescale 1ns/1ps

module rv_branch_unit (
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  rv_pkg::branch_e         branch,
    output logic                    taken
);
    import rv_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    always_comb begin
        case (branch)
            br_beq:  taken = eq;
            br_bne:  taken = !eq;
            br_blt:  taken = lt;
            br_bge:  taken = !lt;
            br_bltu: taken = ltu;
            br_bgeu: taken = !ltu;
            default: taken = 1'b0; // not a branch
        endcase
    end

endmodule

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  rv_pkg::ctrl_t           ctrl,
    output logic [rv_pkg::xlen-1:0] alu_out
);
    import rv_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [4:0]      shamt;

    assign a     = ctrl.a_sel_rs1 ? rs1_data : pc;
    assign b     = ctrl.b_sel_imm ? imm : rs2_data;
    assign shamt = b[4:0]; // also covers shamt of the I-type shifts

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:    alu_out = a - b;
            alu_sll:    alu_out = a << shamt;
            alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   alu_out = {{(xlen-1){1'b0}}, a < b};
            alu_xor:    alu_out = a ^ b;
            alu_srl:    alu_out = a >> shamt;
            alu_sra:    alu_out = $signed(a) >>> shamt;
            alu_or:     alu_out = a | b;
            alu_and:    alu_out = a & b;
            alu_pass_b: alu_out = b;
            default:    alu_out = a + b; // add, also addresses and targets
        endcase
    end

endmodule

// ==== hdl/rv_imm_gen.sv ====
`timescale 1ns/1ps

module rv_imm_gen (
    input  logic [rv_pkg::xlen-1:0] inst,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    logic [6:0] opcode;

    assign opcode = inst[6:0];

    always_comb begin
        case (opcode)
            op_imm, op_load, op_jalr:
                imm = {{20{inst[31]}}, inst[31:20]};
            op_store:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            op_branch:
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            op_lui, op_auipc:
                imm = {inst[31:12], 12'd0};
            op_jal:
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
    input  logic [rv_pkg::xlen-1:0] inst,
    output rv_pkg::ctrl_t           ctrl
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic [4:0] rd;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    // funct7[5] selects sub/sra, but only shifts look at it for op-imm
    assign alt    = inst[30] && (opcode == op_reg || funct3 == 3'b101);

    function automatic alu_op_e alu_fn(input logic [2:0] f3, input logic f7_alt);
        case (f3)
            3'b000:  return f7_alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return f7_alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = alu_add;
        ctrl.branch   = br_none;
        ctrl.wb_sel   = wb_none;
        ctrl.mem_size = mem_w;
        ctrl.flow     = flow_plain;
        case (opcode)
            op_lui: begin
                ctrl.b_sel_imm = 1'b1;
                ctrl.alu_op    = alu_pass_b;
                ctrl.rd_we     = 1'b1;
                ctrl.wb_sel    = wb_alu;
            end
            op_auipc: begin
                ctrl.b_sel_imm = 1'b1; // pc + imm
                ctrl.rd_we     = 1'b1;
                ctrl.wb_sel    = wb_alu;
            end
            op_jal: begin
                ctrl.b_sel_imm = 1'b1;
                ctrl.is_jump   = 1'b1;
                ctrl.rd_we     = 1'b1;
                ctrl.wb_sel    = wb_pc_plus4;
                ctrl.flow      = (rd == 5'd1) ? flow_call : flow_plain;
            end
            op_jalr: begin
                ctrl.a_sel_rs1 = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.is_jump   = 1'b1;
                ctrl.rd_we     = 1'b1;
                ctrl.wb_sel    = wb_pc_plus4;
                if (inst == ret_inst)
                    ctrl.flow = flow_ret;
                else if (rd == 5'd1)
                    ctrl.flow = flow_call;
                else if (rd == 5'd0 && inst[31:20] == 12'd0)
                    ctrl.flow = flow_tail; // jump without link
            end
            op_branch: begin
                ctrl.b_sel_imm = 1'b1; // target is pc + imm
                if (funct3[2:1] != 2'b01)
                    ctrl.branch = branch_e'(funct3);
            end
            op_load: begin
                ctrl.a_sel_rs1 = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.rd_we     = 1'b1;
                ctrl.wb_sel    = wb_mem;
                ctrl.mem_rd    = 1'b1;
                ctrl.mem_size  = mem_size_e'(funct3);
            end
            op_store: begin
                ctrl.a_sel_rs1 = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.mem_wr    = 1'b1;
                ctrl.mem_size  = mem_size_e'(funct3);
            end
            op_imm, op_reg: begin
                ctrl.a_sel_rs1 = 1'b1;
                ctrl.b_sel_imm = (opcode == op_imm);
                ctrl.alu_op    = alu_fn(funct3, alt);
                ctrl.rd_we     = 1'b1;
                ctrl.wb_sel    = wb_alu;
            end
            default: ; // retires as a no-op
        endcase
    end

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen       = 32;
    localparam int dmem_words = 256;
    localparam int dmem_aw    = $clog2(dmem_words);

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam logic [xlen-1:0] ret_inst = 32'h0000_8067; // jalr x0, 0(ra)

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // lui
    } alu_op_e;

    // values follow funct3 of the branch opcode
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_none = 3'b010,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_e;

    // values follow funct3 of load/store
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_size_e;

    typedef enum logic [1:0] {
        wb_none     = 2'b00,
        wb_pc_plus4 = 2'b01,
        wb_alu      = 2'b10,
        wb_mem      = 2'b11
    } wb_sel_e;

    typedef enum logic [1:0] {
        flow_plain,
        flow_call,
        flow_ret,
        flow_tail
    } flow_e;

    typedef struct packed {
        logic      a_sel_rs1; // 0 selects pc
        logic      b_sel_imm; // 0 selects rs2
        alu_op_e   alu_op;
        branch_e   branch;
        logic      is_jump;
        logic      rd_we;
        wb_sel_e   wb_sel;
        logic      mem_rd;
        logic      mem_wr;
        mem_size_e mem_size;
        flow_e     flow;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic            rd_we;
        logic [xlen-1:0] rd_data;
        logic [xlen-1:0] next_pc;
        flow_e           flow;
    } retire_t;

endpackage
